// File: src/soc_bus_pkg.sv
package soc_bus_pkg;

    // Widths with a meaning on the system bus
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0]  bus_sel_t;
    // Word address on the external SRAM
    typedef logic [19:0] sram_addr_t;

    // Master to slave, strobe/acknowledge handshake
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        bus_sel_t  sel;
        bus_addr_t adr;
        bus_data_t dat;
    } bus_req_t;

    // Slave to master, single-cycle ack or err
    typedef struct packed {
        logic      ack;
        logic      err;
        bus_data_t dat;
    } bus_rsp_t;

    typedef enum logic [1:0] {GRANT_NONE, GRANT_DATA, GRANT_INST} grant_t;

    typedef enum logic [1:0] {SRAM_IDLE, SRAM_ACCESS, SRAM_DONE} sram_state_t;

    // Default address map, 4 MB of SRAM and a 1 MB timer window
    localparam bus_addr_t SRAM_BASE_DEF  = 32'h8000_0000;
    localparam bus_addr_t SRAM_MASK_DEF  = 32'hFFC0_0000;
    localparam bus_addr_t CLINT_BASE_DEF = 32'h0200_0000;
    localparam bus_addr_t CLINT_MASK_DEF = 32'hFFF0_0000;

    // Timer register offsets inside the window
    localparam logic [15:0] MTIMECMP_LO_OFS = 16'h4000;
    localparam logic [15:0] MTIMECMP_HI_OFS = 16'h4004;
    localparam logic [15:0] MTIME_LO_OFS    = 16'hBFF8;
    localparam logic [15:0] MTIME_HI_OFS    = 16'hBFFC;

endpackage

// File: src/bus_arbiter.sv
`timescale 1ns/10ps

module bus_arbiter
    import soc_bus_pkg::*;
(
    input  logic     sys_clk,
    input  logic     sys_rst,

    // Data master with higher priority
    input  bus_req_t data_req_i,
    output bus_rsp_t data_rsp_o,

    // Instruction fetch master
    input  bus_req_t inst_req_i,
    output bus_rsp_t inst_rsp_o,

    // Shared bus towards the decoder
    output bus_req_t bus_req_o,
    input  bus_rsp_t bus_rsp_i
);

    grant_t grant_q;

    logic data_pending;
    logic inst_pending;
    logic xfer_done;

    // A master is pending while it holds cyc and stb
    assign data_pending = data_req_i.cyc && data_req_i.stb;
    assign inst_pending = inst_req_i.cyc && inst_req_i.stb;

    // Either response pulse ends the transfer
    assign xfer_done = bus_rsp_i.ack || bus_rsp_i.err;

    // Grant register
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            grant_q <= GRANT_NONE;
        end else begin
            case (grant_q)
                GRANT_NONE: begin
                    // Fixed priority with data first
                    if (data_pending) begin
                        grant_q <= GRANT_DATA;
                    end else if (inst_pending) begin
                        grant_q <= GRANT_INST;
                    end
                end
                GRANT_DATA, GRANT_INST: begin
                    // Held until the slave answers and never preempted
                    if (xfer_done) begin
                        grant_q <= GRANT_NONE;
                    end
                end
                default: begin
                    grant_q <= GRANT_NONE;
                end
            endcase
        end
    end

    // Forward the winner and steer the response back to it only
    always_comb begin
        bus_req_o  = '0;
        data_rsp_o = '0;
        inst_rsp_o = '0;
        case (grant_q)
            GRANT_DATA: begin
                bus_req_o  = data_req_i;
                data_rsp_o = bus_rsp_i;
            end
            GRANT_INST: begin
                bus_req_o  = inst_req_i;
                inst_rsp_o = bus_rsp_i;
            end
            default: begin
                // Idle bus drives nothing
            end
        endcase
    end

endmodule

// File: src/addr_decoder.sv
`timescale 1ns/10ps

module addr_decoder
    import soc_bus_pkg::*;
#(
    parameter bus_addr_t SRAM_BASE  = SRAM_BASE_DEF,
    parameter bus_addr_t SRAM_MASK  = SRAM_MASK_DEF,
    parameter bus_addr_t CLINT_BASE = CLINT_BASE_DEF,
    parameter bus_addr_t CLINT_MASK = CLINT_MASK_DEF
) (
    input  logic     sys_clk,
    input  logic     sys_rst,

    // From the arbiter
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,

    // Slave 0, SRAM controller
    output bus_req_t sram_req_o,
    input  bus_rsp_t sram_rsp_i,

    // Slave 1, core-local timer
    output bus_req_t clint_req_o,
    input  bus_rsp_t clint_rsp_i
);

    logic req_valid;
    logic sram_hit;
    logic clint_hit;
    logic err_q;

    assign req_valid = bus_req_i.cyc && bus_req_i.stb;

    // Masked compare against each base
    assign sram_hit  = (bus_req_i.adr & SRAM_MASK) == SRAM_BASE;
    assign clint_hit = (bus_req_i.adr & CLINT_MASK) == CLINT_BASE;

    // Same request to both slaves, strobe only where the address hits
    always_comb begin
        sram_req_o      = bus_req_i;
        sram_req_o.stb  = bus_req_i.stb && sram_hit;
        clint_req_o     = bus_req_i;
        clint_req_o.stb = bus_req_i.stb && clint_hit;
    end

    // Unmapped access answered one cycle later
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            err_q <= 1'b0;
        end else begin
            // Single pulse even though stb is still held
            err_q <= req_valid && !sram_hit && !clint_hit && !err_q;
        end
    end

    // Merge responses, data from whichever slave acks
    always_comb begin
        bus_rsp_o.ack = sram_rsp_i.ack || clint_rsp_i.ack;
        bus_rsp_o.err = sram_rsp_i.err || clint_rsp_i.err || err_q;
        if (sram_rsp_i.ack) begin
            bus_rsp_o.dat = sram_rsp_i.dat;
        end else if (clint_rsp_i.ack) begin
            bus_rsp_o.dat = clint_rsp_i.dat;
        end else begin
            // Error and idle read as zero
            bus_rsp_o.dat = '0;
        end
    end

endmodule

// File: src/sram_ctrl.sv
`timescale 1ns/10ps

module sram_ctrl
    import soc_bus_pkg::*;
(
    input  logic            sys_clk,
    input  logic            sys_rst,

    // Bus slave side
    input  bus_req_t        bus_req_i,
    output bus_rsp_t        bus_rsp_o,

    // Asynchronous SRAM pins, controls active low
    output sram_addr_t      sram_addr_o,
    inout  wire  bus_data_t sram_data_io,
    output bus_sel_t        sram_be_n_o,
    output logic            sram_ce_n_o,
    output logic            sram_oe_n_o,
    output logic            sram_we_n_o
);

    sram_state_t state_q;
    sram_state_t state_d;

    logic      start;
    logic      drive_q;
    bus_data_t wdata_q;
    bus_data_t rdata_q;

    // New cycle accepted only from idle
    assign start = (state_q == SRAM_IDLE) && bus_req_i.cyc && bus_req_i.stb;

    // IDLE -> ACCESS -> DONE, one cycle each after the start
    always_comb begin
        state_d = state_q;
        case (state_q)
            SRAM_IDLE: begin
                if (start) begin
                    state_d = SRAM_ACCESS;
                end
            end
            SRAM_ACCESS: begin
                state_d = SRAM_DONE;
            end
            SRAM_DONE: begin
                state_d = SRAM_IDLE;
            end
            default: begin
                state_d = SRAM_IDLE;
            end
        endcase
    end

    // State and pin controls
    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            state_q     <= SRAM_IDLE;
            sram_ce_n_o <= 1'b1;
            sram_oe_n_o <= 1'b1;
            sram_we_n_o <= 1'b1;
            drive_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (start) begin
                // Enter ACCESS with the chip selected
                sram_ce_n_o <= 1'b0;
                sram_oe_n_o <= bus_req_i.we;
                sram_we_n_o <= !bus_req_i.we;
                drive_q     <= bus_req_i.we;
            end else if (state_q == SRAM_ACCESS) begin
                // Release everything going into DONE
                sram_ce_n_o <= 1'b1;
                sram_oe_n_o <= 1'b1;
                sram_we_n_o <= 1'b1;
                drive_q     <= 1'b0;
            end
        end
    end

    // Address, byte enables and write data latched at the start
    always_ff @(posedge sys_clk) begin
        if (start) begin
            sram_addr_o <= bus_req_i.adr[21:2];
            sram_be_n_o <= ~bus_req_i.sel;
            wdata_q     <= bus_req_i.dat;
        end
        // Read sample at the end of ACCESS
        if (state_q == SRAM_ACCESS && !sram_oe_n_o) begin
            rdata_q <= sram_data_io;
        end
    end

    // Data lines driven for writes only
    assign sram_data_io = drive_q ? wdata_q : 'z;

    assign bus_rsp_o.ack = (state_q == SRAM_DONE);
    assign bus_rsp_o.err = 1'b0;
    assign bus_rsp_o.dat = rdata_q;

endmodule

// File: src/clint_timer.sv
`timescale 1ns/10ps

module clint_timer
    import soc_bus_pkg::*;
(
    input  logic     sys_clk,
    input  logic     sys_rst,

    // Bus slave side
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o,

    // Machine timer interrupt
    output logic     timer_irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic        ack_q;
    bus_data_t   rdata_q;

    logic        access;
    logic        wr_access;
    logic [15:0] ofs;

    // Replace only the selected bytes of a half
    function automatic bus_data_t merge_bytes(bus_data_t old_val, bus_data_t new_val,
                                              bus_sel_t sel);
        bus_data_t result;
        result = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                result[i*8 +: 8] = new_val[i*8 +: 8];
            end
        end
        return result;
    endfunction

    // One access per strobe since the held stb is ignored during ack
    assign access    = bus_req_i.cyc && bus_req_i.stb && !ack_q;
    assign wr_access = access && bus_req_i.we;
    assign ofs       = bus_req_i.adr[15:0];

    always_ff @(posedge sys_clk or posedge sys_rst) begin
        if (sys_rst) begin
            mtime_q     <= '0;
            // All ones keeps the interrupt quiet after reset
            mtimecmp_q  <= '1;
            ack_q       <= 1'b0;
            timer_irq_o <= 1'b0;
        end else begin
            ack_q       <= access;
            timer_irq_o <= (mtime_q >= mtimecmp_q);
            // Free running count where a write to a half wins
            mtime_q     <= mtime_q + 64'd1;
            if (wr_access) begin
                case (ofs)
                    MTIME_LO_OFS: begin
                        mtime_q[31:0] <= merge_bytes(mtime_q[31:0], bus_req_i.dat,
                                                     bus_req_i.sel);
                    end
                    MTIME_HI_OFS: begin
                        mtime_q[63:32] <= merge_bytes(mtime_q[63:32], bus_req_i.dat,
                                                      bus_req_i.sel);
                    end
                    MTIMECMP_LO_OFS: begin
                        mtimecmp_q[31:0] <= merge_bytes(mtimecmp_q[31:0], bus_req_i.dat,
                                                        bus_req_i.sel);
                    end
                    MTIMECMP_HI_OFS: begin
                        mtimecmp_q[63:32] <= merge_bytes(mtimecmp_q[63:32], bus_req_i.dat,
                                                         bus_req_i.sel);
                    end
                    default: begin
                        // Writes elsewhere are dropped
                    end
                endcase
            end
        end
    end

    // Read mux where unknown offsets read zero
    always_ff @(posedge sys_clk) begin
        if (access) begin
            case (ofs)
                MTIME_LO_OFS:    rdata_q <= mtime_q[31:0];
                MTIME_HI_OFS:    rdata_q <= mtime_q[63:32];
                MTIMECMP_LO_OFS: rdata_q <= mtimecmp_q[31:0];
                MTIMECMP_HI_OFS: rdata_q <= mtimecmp_q[63:32];
                default:         rdata_q <= '0;
            endcase
        end
    end

    assign bus_rsp_o.ack = ack_q;
    assign bus_rsp_o.err = 1'b0;
    assign bus_rsp_o.dat = rdata_q;

endmodule

// File: src/mem_fabric_top.sv
`timescale 1ns/10ps

module mem_fabric_top
    import soc_bus_pkg::*;
#(
    parameter bus_addr_t SRAM_BASE  = SRAM_BASE_DEF,
    parameter bus_addr_t SRAM_MASK  = SRAM_MASK_DEF,
    parameter bus_addr_t CLINT_BASE = CLINT_BASE_DEF,
    parameter bus_addr_t CLINT_MASK = CLINT_MASK_DEF
) (
    input  logic            sys_clk,
    input  logic            sys_rst,

    // Two bus masters
    input  bus_req_t        inst_req_i,
    input  bus_req_t        data_req_i,
    output bus_rsp_t        inst_rsp_o,
    output bus_rsp_t        data_rsp_o,

    // External SRAM
    output sram_addr_t      sram_addr_o,
    inout  wire  bus_data_t sram_data_io,
    output bus_sel_t        sram_be_n_o,
    output logic            sram_ce_n_o,
    output logic            sram_oe_n_o,
    output logic            sram_we_n_o,

    output logic            timer_irq_o
);

    // Arbiter to decoder
    bus_req_t arb_req;
    bus_rsp_t arb_rsp;

    // Decoder to slaves
    bus_req_t sram_req;
    bus_rsp_t sram_rsp;
    bus_req_t clint_req;
    bus_rsp_t clint_rsp;

    bus_arbiter u_arbiter (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .data_req_i (data_req_i),
        .inst_req_i (inst_req_i),
        .data_rsp_o (data_rsp_o),
        .inst_rsp_o (inst_rsp_o),
        .bus_req_o  (arb_req),
        .bus_rsp_i  (arb_rsp)
    );

    // Address map comes from the top parameters
    addr_decoder #(
        .SRAM_BASE  (SRAM_BASE),
        .SRAM_MASK  (SRAM_MASK),
        .CLINT_BASE (CLINT_BASE),
        .CLINT_MASK (CLINT_MASK)
    ) u_decoder (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .bus_req_i   (arb_req),
        .bus_rsp_o   (arb_rsp),
        .sram_req_o  (sram_req),
        .sram_rsp_i  (sram_rsp),
        .clint_req_o (clint_req),
        .clint_rsp_i (clint_rsp)
    );

    sram_ctrl u_sram_ctrl (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .bus_req_i    (sram_req),
        .bus_rsp_o    (sram_rsp),
        .sram_addr_o  (sram_addr_o),
        .sram_data_io (sram_data_io),
        .sram_be_n_o  (sram_be_n_o),
        .sram_ce_n_o  (sram_ce_n_o),
        .sram_oe_n_o  (sram_oe_n_o),
        .sram_we_n_o  (sram_we_n_o)
    );

    clint_timer u_clint (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .bus_req_i   (clint_req),
        .bus_rsp_o   (clint_rsp),
        .timer_irq_o (timer_irq_o)
    );

endmodule

// File: bench/sram_model.sv
`timescale 1ns/10ps

module sram_model
    import soc_bus_pkg::*;
(
    input  sram_addr_t      sram_addr_i,
    inout  wire  bus_data_t sram_data_io,
    input  bus_sel_t        sram_be_n_i,
    input  logic            sram_ce_n_i,
    input  logic            sram_oe_n_i,
    input  logic            sram_we_n_i
);

    // One 32-bit word per 20-bit word address
    bus_data_t mem [0:(1 << 20) - 1];

    // Write while chip and write enable are both low, byte lanes by be_n
    always @(sram_we_n_i or sram_ce_n_i or sram_addr_i or sram_data_io or sram_be_n_i) begin
        if (!sram_ce_n_i && !sram_we_n_i) begin
            for (int i = 0; i < 4; i++) begin
                if (!sram_be_n_i[i]) begin
                    mem[sram_addr_i][i*8 +: 8] = sram_data_io[i*8 +: 8];
                end
            end
        end
    end

    // Read drive only with output enable low and no write going on
    assign sram_data_io = (!sram_ce_n_i && !sram_oe_n_i && sram_we_n_i) ?
                          mem[sram_addr_i] : 'z;

endmodule

// File: bench/fabric_checker.sv
`timescale 1ns/10ps

module fabric_checker
    import soc_bus_pkg::*;
(
    input logic     sys_clk,
    input logic     sys_rst,
    input bus_req_t data_req_i,
    input bus_req_t inst_req_i,
    input bus_rsp_t data_rsp_i,
    input bus_rsp_t inst_rsp_i,
    input logic     sram_oe_n_i,
    input logic     sram_we_n_i
);

    // Never ack and err in the same cycle
    data_ack_err_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(data_rsp_i.ack && data_rsp_i.err))
        else $error("data port shows ack and err together");
    inst_ack_err_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(inst_rsp_i.ack && inst_rsp_i.err))
        else $error("instruction port shows ack and err together");

    // Responses only inside an open cycle of that master
    data_rsp_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (data_rsp_i.ack || data_rsp_i.err) |-> data_req_i.cyc)
        else $error("data port response without cyc");
    inst_rsp_in_cyc: assert property (@(posedge sys_clk) disable iff (sys_rst)
        (inst_rsp_i.ack || inst_rsp_i.err) |-> inst_req_i.cyc)
        else $error("instruction port response without cyc");

    // SRAM never read and written at once
    sram_oe_we_excl: assert property (@(posedge sys_clk) disable iff (sys_rst)
        !(!sram_oe_n_i && !sram_we_n_i))
        else $error("sram oe_n and we_n both low");

endmodule

// File: bench/fabric_tb.sv
`timescale 1ns/10ps

module fabric_tb
    import soc_bus_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 10;
    localparam int NUM_TESTS  = 6;
    localparam int RSP_LIMIT  = 32;
    localparam int NUM_WORDS  = 8;
    localparam int IRQ_LIMIT  = 200;

    logic       sys_clk;
    logic       sys_rst;
    bus_req_t   data_req;
    bus_req_t   inst_req;
    bus_rsp_t   data_rsp;
    bus_rsp_t   inst_rsp;
    sram_addr_t sram_addr;
    wire bus_data_t sram_data;
    bus_sel_t   sram_be_n;
    logic       sram_ce_n;
    logic       sram_oe_n;
    logic       sram_we_n;
    logic       timer_irq;

    int errors    = 0;
    int checks    = 0;
    int cycle_cnt = 0;

    // Words of the first test that later tests read again
    bus_addr_t word_adr [NUM_WORDS];
    bus_data_t word_dat [NUM_WORDS];

    mem_fabric_top #(
        .SRAM_BASE  (SRAM_BASE_DEF),
        .SRAM_MASK  (SRAM_MASK_DEF),
        .CLINT_BASE (CLINT_BASE_DEF),
        .CLINT_MASK (CLINT_MASK_DEF)
    ) dut_i (
        .sys_clk      (sys_clk),
        .sys_rst      (sys_rst),
        .inst_req_i   (inst_req),
        .data_req_i   (data_req),
        .inst_rsp_o   (inst_rsp),
        .data_rsp_o   (data_rsp),
        .sram_addr_o  (sram_addr),
        .sram_data_io (sram_data),
        .sram_be_n_o  (sram_be_n),
        .sram_ce_n_o  (sram_ce_n),
        .sram_oe_n_o  (sram_oe_n),
        .sram_we_n_o  (sram_we_n),
        .timer_irq_o  (timer_irq)
    );

    sram_model u_sram (
        .sram_addr_i  (sram_addr),
        .sram_data_io (sram_data),
        .sram_be_n_i  (sram_be_n),
        .sram_ce_n_i  (sram_ce_n),
        .sram_oe_n_i  (sram_oe_n),
        .sram_we_n_i  (sram_we_n)
    );

    bind mem_fabric_top fabric_checker u_checker (
        .sys_clk     (sys_clk),
        .sys_rst     (sys_rst),
        .data_req_i  (data_req_i),
        .inst_req_i  (inst_req_i),
        .data_rsp_i  (data_rsp_o),
        .inst_rsp_i  (inst_rsp_o),
        .sram_oe_n_i (sram_oe_n_o),
        .sram_we_n_i (sram_we_n_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // Cycle stamp for response ordering
    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Watchdog allows 2000 cycles per test
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("Watchdog timeout: run passed %0d cycles with %0d errors so far",
                 NUM_TESTS * 2000, errors);
        $display("Done: errors found");
        $finish;
    end

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error @ %0t ns: %s: got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic drive_req(input bit use_inst, input bus_req_t req);
        if (use_inst) begin
            inst_req = req;
        end else begin
            data_req = req;
        end
    endtask

    // One transfer on either port with the request held until ack or err
    task automatic transfer(input bit use_inst, input bit we, input bus_addr_t adr,
                            input bus_data_t wdat, input bus_sel_t sel,
                            output bus_data_t rdat, output bit got_ack,
                            output bit got_err, output int rsp_cycle);
        bus_req_t req;
        bus_rsp_t rsp;
        int       waited;
        req       = {1'b1, 1'b1, we, sel, adr, wdat};
        rdat      = '0;
        got_ack   = 1'b0;
        got_err   = 1'b0;
        rsp_cycle = -1;
        waited    = 0;
        @(negedge sys_clk);
        drive_req(use_inst, req);
        while (!got_ack && !got_err && waited < RSP_LIMIT) begin
            @(negedge sys_clk);
            waited++;
            rsp = use_inst ? inst_rsp : data_rsp;
            got_ack   = rsp.ack;
            got_err   = rsp.err;
            rdat      = rsp.dat;
            rsp_cycle = cycle_cnt;
        end
        if (!got_ack && !got_err) begin
            errors++;
            $display("Missing response: %s port got neither ack nor err in %0d cycles at 0x%h",
                     use_inst ? "instruction" : "data", RSP_LIMIT, adr);
        end
        // Keep cyc through the response cycle and drop it in the next one
        @(negedge sys_clk);
        drive_req(use_inst, '0);
    endtask

    task automatic bus_write(input bit use_inst, input bus_addr_t adr, input bus_data_t dat,
                             input bus_sel_t sel, input bit expect_err);
        bus_data_t rdat;
        bit        got_ack;
        bit        got_err;
        int        at_cycle;
        transfer(use_inst, 1'b1, adr, dat, sel, rdat, got_ack, got_err, at_cycle);
        check(got_ack, !expect_err, $sformatf("write ack at 0x%h", adr));
        check(got_err, expect_err, $sformatf("write err at 0x%h", adr));
    endtask

    task automatic bus_read(input bit use_inst, input bus_addr_t adr,
                            output bus_data_t rdat, input bit expect_err);
        bit got_ack;
        bit got_err;
        int at_cycle;
        transfer(use_inst, 1'b0, adr, '0, 4'hF, rdat, got_ack, got_err, at_cycle);
        check(got_ack, !expect_err, $sformatf("read ack at 0x%h", adr));
        check(got_err, expect_err, $sformatf("read err at 0x%h", adr));
    endtask

    task automatic reset_outputs();
        check(sram_ce_n, 1'b1, "sram_ce_n in reset");
        check(sram_oe_n, 1'b1, "sram_oe_n in reset");
        check(sram_we_n, 1'b1, "sram_we_n in reset");
        check(data_rsp.ack || data_rsp.err, 1'b0, "data response in reset");
        check(inst_rsp.ack || inst_rsp.err, 1'b0, "instruction response in reset");
    endtask

    // Random words written through the data port and read back through both
    task automatic sram_rw_both_ports();
        bus_data_t rdat;
        for (int i = 0; i < NUM_WORDS; i++) begin
            // Upper word-address bits from the index keep the words apart
            word_adr[i] = SRAM_BASE_DEF | {10'd0, 4'(i), 16'($urandom), 2'b00};
            word_dat[i] = $urandom;
            bus_write(1'b0, word_adr[i], word_dat[i], 4'hF, 1'b0);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            bus_read(1'b0, word_adr[i], rdat, 1'b0);
            check(rdat, word_dat[i], "data port read back");
            bus_read(1'b1, word_adr[i], rdat, 1'b0);
            check(rdat, word_dat[i], "instruction port read back");
        end
    endtask

    task automatic byte_lane_merge();
        bus_addr_t adr;
        bus_data_t orig;
        bus_data_t lo;
        bus_data_t hi;
        bus_data_t expected;
        bus_data_t rdat;
        adr  = SRAM_BASE_DEF | 32'h003C_1230;
        orig = $urandom;
        lo   = $urandom;
        hi   = $urandom;
        bus_write(1'b0, adr, orig, 4'hF, 1'b0);
        bus_write(1'b0, adr, lo, 4'b0001, 1'b0);
        bus_write(1'b1, adr, hi, 4'b0100, 1'b0);
        // Only lanes 0 and 2 replaced
        expected        = orig;
        expected[7:0]   = lo[7:0];
        expected[23:16] = hi[23:16];
        bus_read(1'b0, adr, rdat, 1'b0);
        check(rdat, expected, "byte-select merge");
    endtask

    // Both masters start on the same edge and data has priority
    task automatic same_cycle_priority();
        bus_data_t d_dat;
        bus_data_t i_dat;
        bit        d_ack;
        bit        d_err;
        bit        i_ack;
        bit        i_err;
        int        d_cyc;
        int        i_cyc;
        fork
            transfer(1'b0, 1'b0, word_adr[0], '0, 4'hF, d_dat, d_ack, d_err, d_cyc);
            transfer(1'b1, 1'b0, word_adr[1], '0, 4'hF, i_dat, i_ack, i_err, i_cyc);
        join
        check(d_ack, 1'b1, "data ack under contention");
        check(i_ack, 1'b1, "instruction ack under contention");
        check(d_dat, word_dat[0], "data read under contention");
        check(i_dat, word_dat[1], "instruction read under contention");
        check(i_cyc > d_cyc, 1'b1, "instruction ack strictly after data ack");
    endtask

    // Guard word sits on the SRAM word that the unmapped address would alias
    task automatic unmapped_error();
        bus_data_t guard;
        bus_data_t rdat;
        guard = $urandom;
        bus_write(1'b0, SRAM_BASE_DEF, guard, 4'hF, 1'b0);
        bus_read(1'b0, 32'h4000_0000, rdat, 1'b1);
        check(rdat, '0, "read data on error");
        bus_write(1'b1, 32'h4000_0000, ~guard, 4'hF, 1'b1);
        bus_read(1'b0, SRAM_BASE_DEF, rdat, 1'b0);
        check(rdat, guard, "sram unchanged after unmapped write");
    endtask

    task automatic mtime_advances();
        bus_data_t first;
        bus_data_t second;
        bus_read(1'b0, CLINT_BASE_DEF | 32'(MTIME_LO_OFS), first, 1'b0);
        repeat (20) @(negedge sys_clk);
        bus_read(1'b1, CLINT_BASE_DEF | 32'(MTIME_LO_OFS), second, 1'b0);
        check(second > first, 1'b1, "mtime low advances");
    endtask

    task automatic irq_rise_fall();
        bus_data_t now;
        bus_data_t cmp;
        int        waited;
        check(timer_irq, 1'b0, "timer interrupt low after reset");
        bus_write(1'b0, CLINT_BASE_DEF | 32'(MTIME_HI_OFS), '0, 4'hF, 1'b0);
        bus_read(1'b0, CLINT_BASE_DEF | 32'(MTIME_LO_OFS), now, 1'b0);
        // Low half first while the high half is still all ones
        cmp = now + 32'd80;
        bus_write(1'b0, CLINT_BASE_DEF | 32'(MTIMECMP_LO_OFS), cmp, 4'hF, 1'b0);
        bus_write(1'b0, CLINT_BASE_DEF | 32'(MTIMECMP_HI_OFS), '0, 4'hF, 1'b0);
        bus_read(1'b0, CLINT_BASE_DEF | 32'(MTIME_LO_OFS), now, 1'b0);
        check(now < cmp, 1'b1, "mtime still below compare value");
        check(timer_irq, 1'b0, "interrupt low before compare value");
        waited = 0;
        while (!timer_irq && waited < IRQ_LIMIT) begin
            @(negedge sys_clk);
            waited++;
        end
        check(timer_irq, 1'b1, "interrupt rises within bounded wait");
        // An early rise would show mtime still below compare
        bus_read(1'b0, CLINT_BASE_DEF | 32'(MTIME_LO_OFS), now, 1'b0);
        check(now >= cmp, 1'b1, "mtime at or past compare value");
        bus_write(1'b0, CLINT_BASE_DEF | 32'(MTIMECMP_HI_OFS), '1, 4'hF, 1'b0);
        @(negedge sys_clk);
        check(timer_irq, 1'b0, "interrupt low after compare raised");
    endtask

    initial begin
        void'($urandom(61884));
        sys_rst  = 1'b1;
        data_req = '0;
        inst_req = '0;
        repeat (RST_CYCLES) @(negedge sys_clk);
        reset_outputs();
        sys_rst = 1'b0;
        sram_rw_both_ports();
        byte_lane_merge();
        same_cycle_priority();
        unmapped_error();
        mtime_advances();
        irq_rise_fall();
        repeat (4) @(negedge sys_clk);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: files.f
src/soc_bus_pkg.sv
src/bus_arbiter.sv
src/addr_decoder.sv
src/sram_ctrl.sv
src/clint_timer.sv
src/mem_fabric_top.sv
bench/sram_model.sv
bench/fabric_checker.sv
bench/fabric_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the memory fabric testbench with Verilator, run it and scan the log
set -u
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fabric_tb \
    -f files.f -o fabric_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/fabric_sim > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
